//--- rtl/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// 640x480 raster counts
`define H_VISIBLE 640
`define H_TOTAL 800
`define H_SYNC_START 656
`define H_SYNC_END 752
`define V_VISIBLE 480
`define V_TOTAL 525
`define V_SYNC_START 490
`define V_SYNC_END 492

// doubled 256 pixel image width on screen
`define BG_WIDTH 512

// video address map
`define PATTERN_END 14'h1FFF
`define NAMETABLE_START 14'h2000
`define PALETTE_START 14'h3F00
`define ATTR_OFFSET 14'h03C0

// 8 KiB of pattern data plus two 1 KiB nametables
`define VMEM_WORDS 10240

`endif

//--- rtl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

	// register offsets inside the cpu window
	typedef enum logic [2:0] {
		CTRL = 3'd0,
		MASK = 3'd1,
		STATUS = 3'd2,
		OAM_ADDR = 3'd3,
		OAM_DATA = 3'd4,
		SCROLL = 3'd5,
		ADDR = 3'd6,
		DATA = 3'd7
	} reg_sel_e;

	typedef struct packed {
		logic valid;
		logic wren;
		reg_sel_e sel;
		logic [7:0] wdata;
	} cpu_bus_req_t;

	typedef struct packed {
		logic valid;
		logic wren;
		logic [13:0] addr;
		logic [7:0] wdata;
	} vmem_req_t;

	// one step per 4 columns of a tile
	typedef enum logic [1:0] {
		NT = 2'd0,
		AT = 2'd1,
		PAT_LO = 2'd2,
		PAT_HI = 2'd3
	} fetch_phase_e;

	// bit 7 down to bit 0
	typedef struct packed {
		logic nmi_enable;
		logic [1:0] unused_6_5;
		logic bg_pattern_sel;
		logic unused_3;
		logic inc32;
		logic [1:0] unused_1_0;
	} ppu_ctrl_t;

	typedef struct packed {
		logic [9:0] draw_x;
		logic [9:0] draw_y;
		logic hblank;
		logic vblank;
		logic in_vblank_frame;
	} raster_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

`default_nettype wire

//--- rtl/ppu_regs.sv
`default_nettype none

`include "ppu_settings.svh"

module ppu_regs (
	input logic reset,
	input logic vga_clk,
	input ppu_pkg::cpu_bus_req_t bus_req,
	output logic ready,
	output logic [7:0] dout,
	input logic vblank,
	output ppu_pkg::ppu_ctrl_t ctrl,
	output logic show_bg,
	output ppu_pkg::vmem_req_t cpu_mem_req,
	input logic cpu_mem_grant,
	input logic [7:0] cpu_mem_rdata,
	output logic pal_wren,
	output logic [4:0] pal_index,
	output logic [7:0] pal_wdata,
	input logic [7:0] pal_rdata
);

	typedef enum logic [1:0] {IDLE, WAIT_GRANT, WAIT_DATA} state_e;

	state_e state;
	logic [7:0] mask_q;
	logic addr_latch;
	logic [13:0] vaddr;
	logic [13:0] vaddr_step;
	logic new_access;
	logic to_palette;

	// ready high marks the last cycle of the current request
	assign new_access = (state == IDLE) && bus_req.valid && !ready;
	assign to_palette = (vaddr >= `PALETTE_START);
	assign vaddr_step = ctrl.inc32 ? 14'd32 : 14'd1;
	assign show_bg = mask_q[3];

	always_comb begin
		cpu_mem_req.valid = (state == WAIT_GRANT);
		cpu_mem_req.wren = bus_req.wren;
		cpu_mem_req.addr = vaddr;
		cpu_mem_req.wdata = bus_req.wdata;
	end

	// palette writes finish in the accepting cycle
	assign pal_wren = new_access && bus_req.wren && (bus_req.sel == ppu_pkg::DATA) && to_palette;
	assign pal_index = vaddr[4:0];
	assign pal_wdata = bus_req.wdata;

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			state <= IDLE;
			ready <= 1'b0;
			ctrl <= '0;
			mask_q <= 8'h00;
			addr_latch <= 1'b0;
			vaddr <= 14'h0000;
		end else begin
			ready <= 1'b0;
			case (state)
				IDLE: begin
					if (new_access) begin
						if (bus_req.sel == ppu_pkg::DATA && !to_palette) begin
							state <= WAIT_GRANT;
						end else begin
							ready <= 1'b1;
							dout <= 8'h00;
							case (bus_req.sel)
								ppu_pkg::CTRL: begin
									if (bus_req.wren) begin
										ctrl <= ppu_pkg::ppu_ctrl_t'(bus_req.wdata);
									end
								end
								ppu_pkg::MASK: begin
									if (bus_req.wren) begin
										mask_q <= bus_req.wdata;
									end
								end
								ppu_pkg::STATUS: begin
									if (!bus_req.wren) begin
										dout <= {vblank, 7'b0000000};
										addr_latch <= 1'b0;
									end
								end
								ppu_pkg::ADDR: begin
									if (bus_req.wren) begin
										// high byte first, then low byte
										if (!addr_latch) begin
											vaddr[13:8] <= bus_req.wdata[5:0];
										end else begin
											vaddr[7:0] <= bus_req.wdata;
										end
										addr_latch <= !addr_latch;
									end
								end
								ppu_pkg::DATA: begin
									if (!bus_req.wren) begin
										dout <= pal_rdata;
									end
									vaddr <= vaddr + vaddr_step;
								end
								default: begin
									// oam and scroll offsets do nothing here
								end
							endcase
						end
					end
				end
				WAIT_GRANT: begin
					if (cpu_mem_grant) begin
						if (bus_req.wren) begin
							ready <= 1'b1;
							vaddr <= vaddr + vaddr_step;
							state <= IDLE;
						end else begin
							state <= WAIT_DATA;
						end
					end
				end
				WAIT_DATA: begin
					dout <= cpu_mem_rdata;
					ready <= 1'b1;
					vaddr <= vaddr + vaddr_step;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/vram_arbiter.sv
`default_nettype none

module vram_arbiter (
	input logic reset,
	input logic vga_clk,
	input ppu_pkg::vmem_req_t fetch_mem_req,
	input ppu_pkg::vmem_req_t cpu_mem_req,
	output logic fetch_grant,
	output logic cpu_mem_grant,
	output ppu_pkg::vmem_req_t mem_req
);

	// cpu owner of the previous cycle
	logic cpu_granted_q;

	// fetcher has fixed priority
	assign fetch_grant = fetch_mem_req.valid;

	// at most one cpu grant per pair of cycles
	assign cpu_mem_grant = cpu_mem_req.valid && !fetch_mem_req.valid && !cpu_granted_q;

	always_comb begin
		if (fetch_grant) begin
			mem_req = fetch_mem_req;
		end else begin
			mem_req = cpu_mem_req;
			mem_req.valid = cpu_mem_grant;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			cpu_granted_q <= 1'b0;
		end else begin
			cpu_granted_q <= cpu_mem_grant;
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_mem.sv
`default_nettype none

`include "ppu_settings.svh"

module video_mem (
	input logic vga_clk,
	input ppu_pkg::vmem_req_t mem_req,
	output logic [7:0] rdata
);

	logic [7:0] mem [`VMEM_WORDS];
	logic [13:0] index;

	// vertical mirroring keeps only address bit 10 as nametable select
	always_comb begin
		if (mem_req.addr <= `PATTERN_END) begin
			index = mem_req.addr;
		end else begin
			index = `NAMETABLE_START + {3'b000, mem_req.addr[10:0]};
		end
	end

	always_ff @(posedge vga_clk) begin
		if (mem_req.valid) begin
			if (mem_req.wren) begin
				mem[index] <= mem_req.wdata;
			end
			rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

//--- rtl/vga_timing.sv
`default_nettype none

`include "ppu_settings.svh"

module vga_timing (
	input logic reset,
	input logic vga_clk,
	output ppu_pkg::raster_t raster,
	output logic hs,
	output logic vs
);

	logic [9:0] h_count;
	logic [9:0] v_count;
	logic in_vblank_frame_q;

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			h_count <= 10'd0;
			v_count <= 10'd0;
			in_vblank_frame_q <= 1'b0;
		end else if (h_count == `H_TOTAL - 1) begin
			h_count <= 10'd0;
			if (v_count == `V_TOTAL - 1) begin
				v_count <= 10'd0;
				in_vblank_frame_q <= 1'b0;
			end else begin
				v_count <= v_count + 10'd1;
				// entering the first line below the picture
				if (v_count == `V_VISIBLE - 1) begin
					in_vblank_frame_q <= 1'b1;
				end
			end
		end else begin
			h_count <= h_count + 10'd1;
		end
	end

	// syncs are active low
	assign hs = !((h_count >= `H_SYNC_START) && (h_count < `H_SYNC_END));
	assign vs = !((v_count >= `V_SYNC_START) && (v_count < `V_SYNC_END));

	always_comb begin
		raster.draw_x = h_count;
		raster.draw_y = v_count;
		raster.hblank = (h_count >= `H_VISIBLE);
		raster.vblank = (v_count >= `V_VISIBLE);
		raster.in_vblank_frame = in_vblank_frame_q;
	end

endmodule

`default_nettype wire

//--- rtl/bg_fetch.sv
`default_nettype none

`include "ppu_settings.svh"

module bg_fetch (
	input logic reset,
	input logic vga_clk,
	input ppu_pkg::raster_t raster,
	input ppu_pkg::ppu_ctrl_t ctrl,
	output ppu_pkg::vmem_req_t fetch_mem_req,
	input logic fetch_grant,
	input logic [7:0] mem_rdata,
	output logic [3:0] pixel_index
);

	ppu_pkg::fetch_phase_e phase;
	logic prefetch;
	logic fetch_window;
	logic line_active;
	logic data_due;
	logic [9:0] fetch_y;
	logic [4:0] fetch_row;
	logic [4:0] fetch_col;
	logic [7:0] at_shifted;
	logic [7:0] nt_byte;
	logic [1:0] attr_next;
	logic [7:0] pat_lo_next;
	logic [7:0] pat_hi_next;
	logic [1:0] attr_curr;
	logic [7:0] pat_lo;
	logic [7:0] pat_hi;

	// end of line fetches tile 0 of the next line
	assign prefetch = (raster.draw_x >= `H_TOTAL - 16);
	assign fetch_window = prefetch || (raster.draw_x < `BG_WIDTH - 16);

	always_comb begin
		if (!prefetch) begin
			fetch_y = raster.draw_y;
		end else if (raster.draw_y == `V_TOTAL - 1) begin
			fetch_y = 10'd0;
		end else begin
			fetch_y = raster.draw_y + 10'd1;
		end
	end

	assign line_active = (fetch_y < `V_VISIBLE);
	assign fetch_row = fetch_y[8:4];
	assign fetch_col = prefetch ? 5'd0 : raster.draw_x[8:4] + 5'd1;
	assign phase = ppu_pkg::fetch_phase_e'(raster.draw_x[3:2]);

	always_comb begin
		fetch_mem_req.valid = fetch_window && line_active && (raster.draw_x[1:0] == 2'b00);
		fetch_mem_req.wren = 1'b0;
		fetch_mem_req.wdata = 8'h00;
		case (phase)
			ppu_pkg::NT: fetch_mem_req.addr = `NAMETABLE_START + {4'b0000, fetch_row, fetch_col};
			ppu_pkg::AT: fetch_mem_req.addr = `NAMETABLE_START + `ATTR_OFFSET
				+ {8'b00000000, fetch_row[4:2], fetch_col[4:2]};
			// pattern rows of the tile, low plane then high plane
			ppu_pkg::PAT_LO: fetch_mem_req.addr = {1'b0, ctrl.bg_pattern_sel, nt_byte, 1'b0,
				fetch_y[3:1]};
			default: fetch_mem_req.addr = {1'b0, ctrl.bg_pattern_sel, nt_byte, 1'b1, fetch_y[3:1]};
		endcase
	end

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			data_due <= 1'b0;
		end else begin
			data_due <= fetch_grant;
		end
	end

	// quadrant picked by bit 1 of tile row and column
	assign at_shifted = mem_rdata >> {fetch_row[1], fetch_col[1], 1'b0};

	always_ff @(posedge vga_clk) begin
		if (data_due) begin
			case (phase)
				ppu_pkg::NT: nt_byte <= mem_rdata;
				ppu_pkg::AT: attr_next <= at_shifted[1:0];
				ppu_pkg::PAT_LO: pat_lo_next <= mem_rdata;
				default: pat_hi_next <= mem_rdata;
			endcase
		end
	end

	// each pixel lasts two columns
	always_ff @(posedge vga_clk) begin
		if (raster.draw_x[3:0] == 4'hF) begin
			pat_lo <= pat_lo_next;
			pat_hi <= pat_hi_next;
			attr_curr <= attr_next;
		end else if (raster.draw_x[0]) begin
			pat_lo <= {pat_lo[6:0], 1'b0};
			pat_hi <= {pat_hi[6:0], 1'b0};
		end
	end

	assign pixel_index = {attr_curr, pat_hi[7], pat_lo[7]};

endmodule

`default_nettype wire

//--- rtl/pixel_palette.sv
`default_nettype none

`include "ppu_settings.svh"

module pixel_palette (
	input logic reset,
	input logic vga_clk,
	input ppu_pkg::raster_t raster,
	input logic show_bg,
	input logic [3:0] pixel_index,
	input logic pal_wren,
	input logic [4:0] pal_index,
	input logic [7:0] pal_wdata,
	output logic [7:0] pal_rdata,
	output ppu_pkg::rgb_t rgb
);

	// upper nibble of each channel of the 64 system colours
	localparam ppu_pkg::rgb_t SYS_COLOURS [64] = '{
		12'h555, 12'h017, 12'h019, 12'h308, 12'h406, 12'h503, 12'h500, 12'h310,
		12'h220, 12'h030, 12'h040, 12'h030, 12'h033, 12'h000, 12'h000, 12'h000,
		12'h999, 12'h04C, 12'h33E, 12'h51E, 12'h81B, 12'hA16, 12'h922, 12'h730,
		12'h550, 12'h270, 12'h070, 12'h072, 12'h067, 12'h000, 12'h000, 12'h000,
		12'hEEE, 12'h49E, 12'h77E, 12'hB6E, 12'hE5E, 12'hE5B, 12'hE66, 12'hD82,
		12'hAA0, 12'h7C0, 12'h4D2, 12'h3C6, 12'h3BC, 12'h333, 12'h000, 12'h000,
		12'hEEE, 12'hACE, 12'hBBE, 12'hDBE, 12'hEAE, 12'hEAD, 12'hEBB, 12'hEC9,
		12'hCD7, 12'hBD7, 12'hAE9, 12'h9EB, 12'hADE, 12'hAAA, 12'h000, 12'h000
	};

	logic [7:0] pal_mem [32];
	logic [4:0] cpu_slot;
	logic [4:0] pix_slot;
	logic [5:0] colour_q;
	logic blank_q;

	// entry 0x10 shares storage with the backdrop entry
	function automatic logic [4:0] fold(input logic [4:0] index);
		return (index == 5'h10) ? 5'h00 : index;
	endfunction

	assign cpu_slot = fold(pal_index);
	assign pal_rdata = pal_mem[cpu_slot];

	always_ff @(posedge vga_clk) begin
		if (pal_wren) begin
			pal_mem[cpu_slot] <= pal_wdata;
		end
	end

	// transparent, hidden or right border pixels show the backdrop
	always_comb begin
		if (pixel_index[1:0] == 2'b00 || !show_bg || raster.draw_x >= `BG_WIDTH) begin
			pix_slot = 5'h00;
		end else begin
			pix_slot = {1'b0, pixel_index};
		end
	end

	// two stage pipeline so rgb trails draw_x by 2
	always_ff @(posedge vga_clk) begin
		if (reset) begin
			blank_q <= 1'b1;
			rgb <= '0;
		end else begin
			blank_q <= raster.hblank || raster.vblank;
			rgb <= blank_q ? '0 : SYS_COLOURS[colour_q];
		end
	end

	always_ff @(posedge vga_clk) begin
		colour_q <= pal_mem[pix_slot][5:0];
	end

endmodule

`default_nettype wire

//--- rtl/ppu_top.sv
`default_nettype none

module ppu_top (
	input logic reset,
	input logic vga_clk,
	input ppu_pkg::cpu_bus_req_t bus_req,
	output logic ready,
	output logic [7:0] dout,
	output logic nmi,
	output ppu_pkg::rgb_t rgb,
	output logic hs,
	output logic vs
);

	ppu_pkg::ppu_ctrl_t ctrl;
	ppu_pkg::raster_t raster;
	ppu_pkg::vmem_req_t cpu_mem_req;
	ppu_pkg::vmem_req_t fetch_mem_req;
	ppu_pkg::vmem_req_t mem_req;
	logic show_bg;
	logic cpu_mem_grant;
	logic fetch_grant;
	logic [7:0] mem_rdata;
	logic pal_wren;
	logic [4:0] pal_index;
	logic [7:0] pal_wdata;
	logic [7:0] pal_rdata;
	logic [3:0] pixel_index;

	assign nmi = raster.in_vblank_frame & ctrl.nmi_enable;

	ppu_regs regs (
		.reset(reset), .vga_clk(vga_clk), .bus_req(bus_req), .ready(ready), .dout(dout),
		.vblank(raster.in_vblank_frame), .ctrl(ctrl), .show_bg(show_bg),
		.cpu_mem_req(cpu_mem_req), .cpu_mem_grant(cpu_mem_grant), .cpu_mem_rdata(mem_rdata),
		.pal_wren(pal_wren), .pal_index(pal_index), .pal_wdata(pal_wdata), .pal_rdata(pal_rdata)
	);

	vram_arbiter arbiter (
		.reset(reset), .vga_clk(vga_clk), .fetch_mem_req(fetch_mem_req),
		.cpu_mem_req(cpu_mem_req), .fetch_grant(fetch_grant), .cpu_mem_grant(cpu_mem_grant),
		.mem_req(mem_req)
	);

	video_mem vmem (.vga_clk(vga_clk), .mem_req(mem_req), .rdata(mem_rdata));

	vga_timing timing (.reset(reset), .vga_clk(vga_clk), .raster(raster), .hs(hs), .vs(vs));

	bg_fetch fetch (
		.reset(reset), .vga_clk(vga_clk), .raster(raster), .ctrl(ctrl),
		.fetch_mem_req(fetch_mem_req), .fetch_grant(fetch_grant), .mem_rdata(mem_rdata),
		.pixel_index(pixel_index)
	);

	pixel_palette palette (
		.reset(reset), .vga_clk(vga_clk), .raster(raster), .show_bg(show_bg),
		.pixel_index(pixel_index), .pal_wren(pal_wren), .pal_index(pal_index),
		.pal_wdata(pal_wdata), .pal_rdata(pal_rdata), .rgb(rgb)
	);

endmodule

`default_nettype wire

//--- test/ppu_checker.sv
`default_nettype none

`include "ppu_settings.svh"

module ppu_checker (
	input logic vga_clk,
	input logic reset,
	input logic ready,
	input logic [7:0] dout,
	input logic nmi,
	input ppu_pkg::rgb_t rgb,
	input logic hs,
	input logic vs,
	input logic read_chk,
	input logic [7:0] exp_data,
	input logic [159:0] check_name,
	input logic count_req,
	input logic nmi_allowed,
	output logic frame_done,
	output int error_count,
	output int check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// system colours 0x21 and 0x0f, upper nibbles
	localparam ppu_pkg::rgb_t BG_COLOUR = 12'h49E;
	localparam ppu_pkg::rgb_t BACKDROP_COLOUR = 12'h000;
	localparam int BG_EXPECTED = `BG_WIDTH * `V_VISIBLE;
	localparam int BACKDROP_EXPECTED = (`H_VISIBLE - `BG_WIDTH) * `V_VISIBLE;

	logic reset_q = 1'b1;
	logic vs_q = 1'b1;
	logic synced = 1'b0;
	logic counting = 1'b0;
	logic counting_now;
	logic nmi_reported = 1'b0;
	int px = 0;
	int py = 0;
	int bg_pixels = 0;
	int backdrop_pixels = 0;

	initial begin
		frame_done = 1'b0;
		error_count = 0;
		check_count = 0;
	end

	task automatic compare_count(input string name, input int expected, input int actual);
		check_count++;
		if (actual != expected) begin
			error_count++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	always @(negedge vga_clk) begin
		reset_q <= reset;
		vs_q <= vs;
		if (reset_q && !reset) begin
			check_count++;
			if (ready || nmi || rgb != 12'h000 || !hs || !vs) begin
				error_count++;
				$display("** Error after_reset: expected ready nmi rgb 0 hs vs 1, actual %b %b %h %b %b",
					ready, nmi, rgb, hs, vs);
			end
		end
		if (read_chk && ready) begin
			check_count++;
			if (dout !== exp_data) begin
				error_count++;
				$display("** Error %0s: expected %h, actual %h", check_name, exp_data, dout);
			end
		end
		if (!reset && !nmi_allowed && nmi && !nmi_reported) begin
			error_count++;
			nmi_reported <= 1'b1;
			$display("nmi went high while the interrupt was disabled");
		end
		if (nmi_allowed && vs_q && !vs) begin
			check_count++;
			if (!nmi) begin
				error_count++;
				$display("vsync started with nmi still low");
			end
		end
		// rgb trails the counters by 2, so the pixel shown is 2 columns back
		if (!reset && vs && !vs_q) begin
			px <= `H_TOTAL - 1;
			py <= `V_SYNC_END - 1;
			synced <= 1'b1;
		end else if (px == `H_TOTAL - 1) begin
			px <= 0;
			py <= (py == `V_TOTAL - 1) ? 0 : py + 1;
		end else begin
			px <= px + 1;
		end
		counting_now = counting;
		if (synced && count_req && !frame_done && px == 0 && py == 0) begin
			counting_now = 1'b1;
		end
		if (counting_now && px < `H_VISIBLE && py < `V_VISIBLE) begin
			if (rgb == BG_COLOUR) begin
				bg_pixels++;
			end else if (rgb == BACKDROP_COLOUR) begin
				backdrop_pixels++;
			end
		end
		if (counting_now && px == `H_VISIBLE - 1 && py == `V_VISIBLE - 1) begin
			compare_count("frame_bg_pixels", BG_EXPECTED, bg_pixels);
			compare_count("frame_backdrop_pixels", BACKDROP_EXPECTED, backdrop_pixels);
			frame_done <= 1'b1;
			counting <= 1'b0;
		end else begin
			counting <= counting_now;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_ppu.sv
`default_nettype none

`include "ppu_settings.svh"

module tb_ppu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

	// entry kinds
	localparam logic [2:0] OP_BUS = 3'd0;
	localparam logic [2:0] OP_FILL = 3'd1;
	localparam logic [2:0] OP_FRAME = 3'd2;
	localparam logic [2:0] OP_NMI_ON = 3'd3;
	localparam logic [2:0] OP_WAIT_NMI = 3'd4;

	typedef struct packed {
		logic [2:0] op;
		logic [159:0] name;
		ppu_pkg::reg_sel_e sel;
		logic wren;
		logic [7:0] data;
		logic chk;
		logic [7:0] exp;
		logic [10:0] count;
	} entry_t;

	logic vga_clk;
	logic reset;
	ppu_pkg::cpu_bus_req_t bus_req;
	logic ready;
	logic [7:0] dout;
	logic nmi;
	ppu_pkg::rgb_t rgb;
	logic hs;
	logic vs;
	logic read_chk;
	logic [7:0] exp_data;
	logic [159:0] check_name;
	logic count_req;
	logic nmi_allowed;
	logic frame_done;
	int error_count;
	int check_count;
	entry_t table_q[$];
	int cycles = 0;
	int limit = 0;

	ppu_top DUT (
		.reset(reset), .vga_clk(vga_clk), .bus_req(bus_req), .ready(ready), .dout(dout),
		.nmi(nmi), .rgb(rgb), .hs(hs), .vs(vs)
	);

	ppu_checker monitor (
		.vga_clk(vga_clk), .reset(reset), .ready(ready), .dout(dout), .nmi(nmi), .rgb(rgb),
		.hs(hs), .vs(vs), .read_chk(read_chk), .exp_data(exp_data), .check_name(check_name),
		.count_req(count_req), .nmi_allowed(nmi_allowed), .frame_done(frame_done),
		.error_count(error_count), .check_count(check_count)
	);

	initial begin
		vga_clk = 1'b0;
		forever #4 vga_clk = ~vga_clk;
	end

	always @(posedge vga_clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic add_bus(input logic [159:0] name, input ppu_pkg::reg_sel_e sel,
		input logic wren, input logic [7:0] data, input logic [7:0] exp);
		entry_t e;
		e = '{OP_BUS, name, sel, wren, data, !wren, exp, 11'd1};
		table_q.push_back(e);
	endtask

	task automatic add_op(input logic [2:0] op, input logic [159:0] name,
		input logic [7:0] data, input logic [10:0] count);
		entry_t e;
		e = '{op, name, ppu_pkg::DATA, 1'b1, data, 1'b0, 8'h00, count};
		table_q.push_back(e);
	endtask

	task automatic set_addr(input logic [159:0] name, input logic [13:0] addr);
		add_bus(name, ppu_pkg::ADDR, 1'b1, {2'b00, addr[13:8]}, 8'h00);
		add_bus(name, ppu_pkg::ADDR, 1'b1, addr[7:0], 8'h00);
	endtask

	task automatic build_table;
		add_bus("ctrl_clear", ppu_pkg::CTRL, 1'b1, 8'h00, 8'h00);
		set_addr("inc1_addr", 14'h2000);
		add_bus("inc1_wr0", ppu_pkg::DATA, 1'b1, 8'h11, 8'h00);
		add_bus("inc1_wr1", ppu_pkg::DATA, 1'b1, 8'h22, 8'h00);
		add_bus("inc1_wr2", ppu_pkg::DATA, 1'b1, 8'h33, 8'h00);
		add_bus("inc1_wr3", ppu_pkg::DATA, 1'b1, 8'h44, 8'h00);
		set_addr("inc1_raddr", 14'h2000);
		add_bus("inc1_rd0", ppu_pkg::DATA, 1'b0, 8'h00, 8'h11);
		add_bus("inc1_rd1", ppu_pkg::DATA, 1'b0, 8'h00, 8'h22);
		add_bus("inc1_rd2", ppu_pkg::DATA, 1'b0, 8'h00, 8'h33);
		add_bus("inc1_rd3", ppu_pkg::DATA, 1'b0, 8'h00, 8'h44);
		// inc32 writes land 32 bytes apart
		add_bus("ctrl_inc32", ppu_pkg::CTRL, 1'b1, 8'h04, 8'h00);
		set_addr("inc32_addr", 14'h2100);
		add_bus("inc32_wr0", ppu_pkg::DATA, 1'b1, 8'h55, 8'h00);
		add_bus("inc32_wr1", ppu_pkg::DATA, 1'b1, 8'h66, 8'h00);
		set_addr("inc32_raddr", 14'h2100);
		add_bus("inc32_rd0", ppu_pkg::DATA, 1'b0, 8'h00, 8'h55);
		add_bus("inc32_rd1", ppu_pkg::DATA, 1'b0, 8'h00, 8'h66);
		add_bus("ctrl_inc1", ppu_pkg::CTRL, 1'b1, 8'h00, 8'h00);
		set_addr("inc32_gap", 14'h2120);
		add_bus("inc32_rd_2120", ppu_pkg::DATA, 1'b0, 8'h00, 8'h66);
		// vertical mirroring
		set_addr("mirror_addr", 14'h2005);
		add_bus("mirror_wr", ppu_pkg::DATA, 1'b1, 8'hA5, 8'h00);
		set_addr("mirror_raddr", 14'h2805);
		add_bus("mirror_rd_2805", ppu_pkg::DATA, 1'b0, 8'h00, 8'hA5);
		// palette folding
		set_addr("pal_addr", 14'h3F10);
		add_bus("pal_wr_3f10", ppu_pkg::DATA, 1'b1, 8'h2A, 8'h00);
		set_addr("pal_raddr", 14'h3F00);
		add_bus("pal_rd_3f00", ppu_pkg::DATA, 1'b0, 8'h00, 8'h2A);
		set_addr("pal_addr1", 14'h3F01);
		add_bus("pal_wr_3f01", ppu_pkg::DATA, 1'b1, 8'h16, 8'h00);
		set_addr("pal_raddr1", 14'h3F01);
		add_bus("pal_rd_3f01", ppu_pkg::DATA, 1'b0, 8'h00, 8'h16);
		// tile 1 both planes solid, whole screen uses tile 1
		set_addr("pat_addr", 14'h0010);
		add_op(OP_FILL, "pat_fill", 8'hFF, 11'd16);
		set_addr("nt_addr", 14'h2000);
		add_op(OP_FILL, "nt_fill", 8'h01, 11'd960);
		add_op(OP_FILL, "attr_fill", 8'h00, 11'd64);
		set_addr("pal3_addr", 14'h3F03);
		add_bus("pal3_wr", ppu_pkg::DATA, 1'b1, 8'h21, 8'h00);
		set_addr("pal0_addr", 14'h3F00);
		add_bus("pal0_wr", ppu_pkg::DATA, 1'b1, 8'h0F, 8'h00);
		add_bus("mask_show_bg", ppu_pkg::MASK, 1'b1, 8'h08, 8'h00);
		add_op(OP_FRAME, "frame_count", 8'h00, 11'd0);
		// vblank interrupt
		add_op(OP_NMI_ON, "nmi_on", 8'h00, 11'd0);
		add_bus("ctrl_nmi", ppu_pkg::CTRL, 1'b1, 8'h80, 8'h00);
		add_op(OP_WAIT_NMI, "nmi_wait", 8'h00, 11'd0);
		add_bus("status_vblank", ppu_pkg::STATUS, 1'b0, 8'h00, 8'h80);
	endtask

	// holds the request until ready
	task automatic bus_access(input entry_t e);
		@(negedge vga_clk);
		bus_req <= '{1'b1, e.wren, e.sel, e.data};
		read_chk <= e.chk;
		exp_data <= e.exp;
		check_name <= e.name;
		do @(negedge vga_clk); while (!ready);
		bus_req.valid <= 1'b0;
		read_chk <= 1'b0;
	endtask

	task automatic run_entry(input entry_t e);
		entry_t w;
		case (e.op)
			OP_BUS: bus_access(e);
			OP_FILL: begin
				w = e;
				w.sel = ppu_pkg::DATA;
				w.wren = 1'b1;
				w.chk = 1'b0;
				repeat (e.count) bus_access(w);
			end
			OP_FRAME: begin
				@(negedge vga_clk);
				count_req <= 1'b1;
				do @(negedge vga_clk); while (!frame_done);
				count_req <= 1'b0;
			end
			OP_NMI_ON: begin
				@(negedge vga_clk);
				nmi_allowed <= 1'b1;
			end
			default: begin
				do @(negedge vga_clk); while (!nmi);
				do @(negedge vga_clk); while (vs);
			end
		endcase
	endtask

	initial begin
		int accesses;
		reset = 1'b1;
		bus_req = '0;
		read_chk = 1'b0;
		exp_data = 8'h00;
		check_name = '0;
		count_req = 1'b0;
		nmi_allowed = 1'b0;
		build_table();
		accesses = 0;
		foreach (table_q[i]) begin
			accesses += (table_q[i].op == OP_FILL) ? int'(table_q[i].count) : 1;
		end
		// 8 cycles per bus access, two frames for the pixel count and the vblank wait
		limit = accesses * 8 + 2 * FRAME_CYCLES;
		repeat (5) @(posedge vga_clk);
		@(negedge vga_clk);
		reset <= 1'b0;
		foreach (table_q[i]) begin
			run_entry(table_q[i]);
		end
		repeat (4) @(negedge vga_clk);
		$display("errors: %0d, checks: %0d", error_count, check_count);
		if (error_count == 0 && check_count > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/ppu_pkg.sv
rtl/ppu_regs.sv
rtl/vram_arbiter.sv
rtl/video_mem.sv
rtl/vga_timing.sv
rtl/bg_fetch.sv
rtl/pixel_palette.sv
rtl/ppu_top.sv
test/ppu_checker.sv
test/tb_ppu.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = tb_ppu
FILELIST = sources.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
